//--- hw/softmax_defines.svh
`ifndef SOFTMAX_DEFINES_SVH
`define SOFTMAX_DEFINES_SVH

// vector geometry
`define SMX_N          32   // elements per vector
`define SMX_ELEM_W     8    // signed input element
`define SMX_WORD_W     16   // fifo word, two elements
`define SMX_WORDS      16   // words per vector

// arithmetic widths
`define SMX_EXP_W      16   // weight, 65535 at d = 0
`define SMX_SUM_W      21   // 32 weights of 16 bits
`define SMX_PROB_W     8    // output probability

// exponent table
`define SMX_DIFF_MAX   63   // clamp for max - x
`define SMX_EXP_STEPS  4    // entries per halving

`endif

//--- hw/softmax_pkg.sv
`default_nettype none

`include "softmax_defines.svh"

package softmax_pkg;

  typedef logic signed [`SMX_ELEM_W-1:0] elem_t;
  typedef logic [`SMX_WORD_W-1:0]        word_t;
  typedef elem_t [`SMX_N-1:0]            in_vec_t;   // element 0 in the low byte

  typedef logic [`SMX_EXP_W-1:0]  exp_t;
  typedef logic [`SMX_SUM_W-1:0]  sum_t;
  typedef logic [`SMX_PROB_W-1:0] prob_t;
  typedef prob_t [`SMX_N-1:0]     prob_vec_t;

  // weight scaled by 256 over the sum of weights
  typedef struct packed {
    logic [`SMX_EXP_W+`SMX_PROB_W-1:0] dividend;
    sum_t                              divisor;
  } div_req_t;

  typedef enum logic [1:0] {COL_IDLE, COLLECT, HAND_OFF} collect_state_t;

  typedef enum logic [2:0] {CORE_IDLE, FIND_MAX, EXP_SUM, DIVIDE, DELIVER} core_state_t;

  // floor(65535 * 2^(-d/4)), only evaluated as a constant
  function automatic exp_t exp_weight(input int d);
    real w;
    w = 65535.0 * (2.0 ** (-real'(d) / real'(`SMX_EXP_STEPS)));
    return exp_t'(longint'($floor(w)));
  endfunction

endpackage

`default_nettype wire

//--- hw/vector_collector.sv
`timescale 1ns/1ns
`default_nettype none

`include "softmax_defines.svh"

module vector_collector (
  input  logic                 clk,
  input  logic                 rst_n,
  input  softmax_pkg::word_t   fifo_data,
  input  logic                 fifo_empty,
  input  logic                 busy,
  output logic                 rd_en,
  output softmax_pkg::in_vec_t vec,
  output logic                 start
);
  import softmax_pkg::*;

  collect_state_t state;
  logic [$clog2(`SMX_WORDS)-1:0] cnt;  // words popped so far

  // fwft fifo, so the word is already on fifo_data when we pop it
  assign rd_en = (state == COLLECT) && !fifo_empty;
  assign start = (state == HAND_OFF);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= COL_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        COL_IDLE: if (!busy) state <= COLLECT;  // core is free again
        COLLECT: begin
          if (rd_en) begin
            cnt <= cnt + 1'b1;  // wraps back to 0 after the last word
            if (cnt == `SMX_WORDS-1) state <= HAND_OFF;
          end
        end
        HAND_OFF: state <= COL_IDLE;
        default:  state <= COL_IDLE;
      endcase
    end
  end

  // new word enters at the top, first word ends up in elements 0 and 1
  always_ff @(posedge clk) begin
    if (rd_en) vec <= {fifo_data, vec[`SMX_N-1:2]};
  end

  // no pop from an empty fifo, and none while the core still works
  a_pop_ok: assert property (@(posedge clk) disable iff (!rst_n)
    rd_en |-> (!fifo_empty && !busy));

endmodule

`default_nettype wire

//--- hw/serial_divider.sv
`timescale 1ns/1ns
`default_nettype none

`include "softmax_defines.svh"

module serial_divider (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                div_start,
  input  softmax_pkg::div_req_t               div_req,
  output logic [`SMX_EXP_W+`SMX_PROB_W-1:0]   quotient,
  output logic                                div_done
);
  import softmax_pkg::*;

  localparam int q_w = `SMX_EXP_W + `SMX_PROB_W;

  sum_t                   rem_q;
  sum_t                   divisor_q;
  logic [q_w-1:0]         quo_q;   // dividend bits shift out, quotient bits in
  logic [$clog2(q_w)-1:0] cnt;
  logic                   active;

  sum_t              rem_in;
  sum_t              div_in;
  logic [q_w-1:0]    quo_in;
  logic [`SMX_SUM_W:0] trial;
  logic              ge;

  // first step runs in the start cycle straight from the request
  always_comb begin
    rem_in = div_start ? '0 : rem_q;
    quo_in = div_start ? div_req.dividend : quo_q;
    div_in = div_start ? div_req.divisor : divisor_q;
    trial  = {rem_in, quo_in[q_w-1]};
    ge     = (trial >= {1'b0, div_in});
  end

  always_ff @(posedge clk) begin
    if (div_start || active) begin
      rem_q <= ge ? sum_t'(trial - {1'b0, div_in}) : sum_t'(trial);  // restore
      quo_q <= {quo_in[q_w-2:0], ge};
    end
    if (div_start) divisor_q <= div_req.divisor;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active   <= 1'b0;
      cnt      <= '0;
      div_done <= 1'b0;
    end else begin
      div_done <= 1'b0;
      if (div_start) begin
        active <= 1'b1;
        cnt    <= 1;
      end else if (active) begin
        cnt <= cnt + 1'b1;
        if (cnt == q_w-1) begin  // last quotient bit this cycle
          active   <= 1'b0;
          div_done <= 1'b1;
        end
      end
    end
  end

  assign quotient = quo_q;

endmodule

`default_nettype wire

//--- hw/softmax_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "softmax_defines.svh"

module softmax_core (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  softmax_pkg::in_vec_t   vec,
  input  logic                   tx_empty,
  output logic                   busy,
  output softmax_pkg::prob_vec_t result,
  output logic                   res_valid
);
  import softmax_pkg::*;

  localparam int q_w = `SMX_EXP_W + `SMX_PROB_W;

  core_state_t state;
  logic [$clog2(`SMX_N)-1:0] idx;  // element index, shared by all passes
  in_vec_t vec_r;
  elem_t   max_r;
  sum_t    sum_r;
  exp_t    weights [`SMX_N];
  logic    div_wait;  // request issued, waiting for div_done

  logic signed [`SMX_ELEM_W:0]        diff;
  logic [$clog2(`SMX_DIFF_MAX+1)-1:0] diff_cl;
  exp_t                               exp_lut [0:`SMX_DIFF_MAX];
  exp_t                               weight;

  logic           div_start;
  div_req_t       div_req;
  logic [q_w-1:0] quotient;
  logic           div_done;
  prob_t          prob_sat;

  // weight table built at elaboration
  for (genvar g = 0; g <= `SMX_DIFF_MAX; g++) begin : g_exp_lut
    localparam exp_t lut_val = exp_weight(g);
    assign exp_lut[g] = lut_val;
  end

  assign diff    = max_r - vec_r[idx];  // never negative
  assign diff_cl = (diff > `SMX_DIFF_MAX) ? `SMX_DIFF_MAX : diff[$bits(diff_cl)-1:0];
  assign weight  = exp_lut[diff_cl];

  assign busy      = (state != CORE_IDLE);
  assign res_valid = (state == DELIVER) && tx_empty;  // serializer has room

  assign div_start        = (state == DIVIDE) && !div_wait;  // issue cycle
  assign div_req.dividend = {weights[idx], {`SMX_PROB_W{1'b0}}};
  assign div_req.divisor  = sum_r;

  // anything at or above 1.0 saturates to 255
  assign prob_sat = (|quotient[q_w-1:`SMX_PROB_W]) ? '1 : quotient[`SMX_PROB_W-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= CORE_IDLE;
      idx      <= '0;
      max_r    <= '0;
      sum_r    <= '0;
      div_wait <= 1'b0;
    end else begin
      case (state)
        CORE_IDLE: begin
          if (start) begin
            state <= FIND_MAX;
            idx   <= '0;
            max_r <= {1'b1, {(`SMX_ELEM_W-1){1'b0}}};  // most negative
          end
        end
        FIND_MAX: begin
          if (vec_r[idx] > max_r) max_r <= vec_r[idx];
          idx <= idx + 1'b1;
          if (idx == `SMX_N-1) begin
            state <= EXP_SUM;
            sum_r <= '0;
          end
        end
        EXP_SUM: begin
          sum_r <= sum_r + weight;
          idx   <= idx + 1'b1;
          if (idx == `SMX_N-1) state <= DIVIDE;
        end
        DIVIDE: begin
          if (!div_wait) begin
            div_wait <= 1'b1;
          end else if (div_done) begin
            div_wait <= 1'b0;
            idx      <= idx + 1'b1;
            if (idx == `SMX_N-1) state <= DELIVER;
          end
        end
        DELIVER:  if (tx_empty) state <= CORE_IDLE;
        default:  state <= CORE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == CORE_IDLE && start) vec_r <= vec;
    if (state == EXP_SUM) weights[idx] <= weight;
    if (state == DIVIDE && div_wait && div_done) result[idx] <= prob_sat;
  end

  serial_divider u_div (
    .clk       (clk),
    .rst_n     (rst_n),
    .div_start (div_start),
    .div_req   (div_req),
    .quotient  (quotient),
    .div_done  (div_done)
  );

  // max element always contributes 65535, so the divisor cannot be zero
  a_sum_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    (state == EXP_SUM && idx == `SMX_N-1) |=> (sum_r != '0));

endmodule

`default_nettype wire

//--- hw/result_serializer.sv
`timescale 1ns/1ns
`default_nettype none

`include "softmax_defines.svh"

module result_serializer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  softmax_pkg::prob_vec_t result,
  input  logic                   res_valid,
  input  logic                   tx_fifo_en,
  output softmax_pkg::word_t     tx_data,
  output logic                   tx_empty
);
  import softmax_pkg::*;

  word_t                         word_buf [`SMX_WORDS];
  logic [$clog2(`SMX_WORDS)-1:0] ptr;  // next word to hand out
  logic                          pop;

  assign pop = tx_fifo_en && !tx_empty;

  always_ff @(posedge clk) begin
    if (res_valid) begin
      for (int i = 0; i < `SMX_WORDS; i++) begin
        word_buf[i] <= {result[2*i+1], result[2*i]};  // odd element on top
      end
    end
    if (pop) tx_data <= word_buf[ptr];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr      <= '0;
      tx_empty <= 1'b1;
    end else if (res_valid) begin
      ptr      <= '0;
      tx_empty <= 1'b0;
    end else if (pop) begin
      ptr <= ptr + 1'b1;
      if (ptr == `SMX_WORDS-1) tx_empty <= 1'b1;  // same edge as the last word
    end
  end

  // core must never overwrite words that are still queued
  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> tx_empty);

endmodule

`default_nettype wire

//--- hw/softmax_top.sv
`timescale 1ns/1ns
`default_nettype none

module softmax_top (
  input  logic               clk,
  input  logic               rst_n,
  input  softmax_pkg::word_t fifo_data,
  input  logic               fifo_empty,
  output logic               rd_en,
  output softmax_pkg::word_t tx_data,
  output logic               tx_empty,
  input  logic               tx_fifo_en
);
  import softmax_pkg::*;

  in_vec_t   vec;
  logic      start;
  logic      busy;
  prob_vec_t result;
  logic      res_valid;

  vector_collector u_collect (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_data  (fifo_data),
    .fifo_empty (fifo_empty),
    .busy       (busy),
    .rd_en      (rd_en),
    .vec        (vec),
    .start      (start)
  );

  softmax_core u_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .vec       (vec),
    .tx_empty  (tx_empty),   // back-pressure from the output side
    .busy      (busy),
    .result    (result),
    .res_valid (res_valid)
  );

  result_serializer u_ser (
    .clk        (clk),
    .rst_n      (rst_n),
    .result     (result),
    .res_valid  (res_valid),
    .tx_fifo_en (tx_fifo_en),
    .tx_data    (tx_data),
    .tx_empty   (tx_empty)
  );

endmodule

`default_nettype wire

//--- test/softmax_model.svh
// probabilities for one vector, straight from the softmax rules
function automatic prob_vec_t model_probs(input in_vec_t v);
  int        mx;
  int        d;
  int        sum;
  int        w [`SMX_N];
  longint    q;
  prob_vec_t p;
  mx  = -128;
  sum = 0;
  for (int i = 0; i < `SMX_N; i++) begin
    if (int'(v[i]) > mx) mx = v[i];
  end
  for (int i = 0; i < `SMX_N; i++) begin
    d = mx - int'(v[i]);
    if (d > `SMX_DIFF_MAX) d = `SMX_DIFF_MAX;  // clamp
    w[i] = $rtoi(65535.0 * (2.0 ** (-real'(d) / real'(`SMX_EXP_STEPS))));  // positive, so floor
    sum  = sum + w[i];
  end
  for (int i = 0; i < `SMX_N; i++) begin
    q    = (longint'(w[i]) * 256) / sum;
    p[i] = (q > 255) ? 8'hff : q[7:0];  // saturate at 1.0
  end
  return p;
endfunction

task automatic check_word(input string name, input word_t got, input word_t exp);
  if (got !== exp) abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
endtask

//--- test/softmax_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "softmax_defines.svh"

module softmax_tb;
  import softmax_pkg::*;

  logic  clk;
  logic  rst_n;
  word_t fifo_data;
  logic  fifo_empty;
  logic  rd_en;
  word_t tx_data;
  logic  tx_empty;
  logic  tx_fifo_en;

  word_t fifo_q [$];  // upstream fifo contents
  word_t exp_q [$];   // words still expected downstream
  word_t exp_w;
  int    gap_pct;     // chance of a fifo_empty gap
  int    stall_pct;   // chance of tx_fifo_en low
  logic  pop_seen;
  logic  tx_pending;
  int    words_seen;
  int    seed_ret;

  `include "softmax_model.svh"

  softmax_top u_softmax_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_data  (fifo_data),
    .fifo_empty (fifo_empty),
    .rd_en      (rd_en),
    .tx_data    (tx_data),
    .tx_empty   (tx_empty),
    .tx_fifo_en (tx_fifo_en)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  function automatic in_vec_t random_vector();
    in_vec_t v;
    for (int i = 0; i < `SMX_N; i++) v[i] = elem_t'($urandom_range(255));
    return v;
  endfunction

  // word k carries element 2k low and 2k+1 high on both sides
  task automatic send_vector(input in_vec_t v, input prob_vec_t p);
    for (int k = 0; k < `SMX_WORDS; k++) begin
      fifo_q.push_back({v[2*k+1], v[2*k]});
      exp_q.push_back({p[2*k+1], p[2*k]});
    end
  endtask

  task automatic wait_drained(input int max_cycles);
    int n;
    n = 0;
    while (fifo_q.size() > 0 || exp_q.size() > 0) begin
      @(negedge clk);
      n++;
      if (n > max_cycles) abort_run("timed out waiting for the DUT to deliver all words");
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // fifo emulation and downstream stalls driven 1 ns after the edge
  initial begin : drive_inputs
    forever begin
      @(posedge clk);
      #1;
      if (pop_seen && fifo_q.size() > 0) fifo_q.delete(0);
      if (fifo_q.size() == 0 || $urandom_range(99) < gap_pct) begin
        fifo_empty = 1'b1;
      end else begin
        fifo_empty = 1'b0;
        fifo_data  = fifo_q[0];  // fwft shows the front word
      end
      tx_fifo_en = rst_n && ($urandom_range(99) >= stall_pct);
    end
  end

  // sample mid-cycle where everything is settled
  initial begin : watch_outputs
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (rd_en && fifo_empty) abort_run("rd_en was high while the FIFO was empty");
        if (tx_pending) begin
          if (exp_q.size() == 0) abort_run("DUT handed out a word that was not expected");
          exp_w = exp_q.pop_front();
          check_word("tx_data", tx_data, exp_w);
          words_seen++;
        end
        pop_seen   = rd_en;
        tx_pending = tx_fifo_en && !tx_empty;  // word shows up after the next edge
      end
    end
  end

  initial begin : main_flow
    in_vec_t   v;
    prob_vec_t p;
    int        top;
    int        k;
    seed_ret   = $urandom(98063);
    rst_n      = 1'b0;
    fifo_data  = '0;
    fifo_empty = 1'b1;
    tx_fifo_en = 1'b0;
    gap_pct    = 0;
    stall_pct  = 0;
    pop_seen   = 1'b0;
    tx_pending = 1'b0;
    words_seen = 0;

    // one random vector, already waiting in the fifo during reset
    v = random_vector();
    send_vector(v, model_probs(v));
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    check_flag("rd_en", rd_en, 1'b0);
    check_flag("tx_empty", tx_empty, 1'b1);
    wait_drained(3000);

    // all equal so every weight is 65535 and each gets 256/32
    top = $urandom_range(255);
    for (int i = 0; i < `SMX_N; i++) begin
      v[i] = elem_t'(top);
      p[i] = 8'd8;
    end
    send_vector(v, p);
    wait_drained(3000);

    // one dominant element with the rest at least 64 below it
    k   = $urandom_range(`SMX_N-1);
    top = 64 + $urandom_range(63);
    for (int i = 0; i < `SMX_N; i++) begin
      v[i] = elem_t'(-128 + int'($urandom_range(top + 64)));
      p[i] = '0;
    end
    v[k] = elem_t'(top);
    p[k] = 8'hff;
    send_vector(v, p);
    wait_drained(3000);

    // back to back with gaps and stalls
    gap_pct   = 30;
    stall_pct = 40;
    for (int n = 0; n < 20; n++) begin
      v = random_vector();
      send_vector(v, model_probs(v));
    end
    wait_drained(40000);

    @(negedge clk);
    check_flag("tx_empty", tx_empty, 1'b1);
    $display("%0d output words checked", words_seen);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hw
+incdir+test
hw/softmax_pkg.sv
hw/vector_collector.sv
hw/serial_divider.sv
hw/softmax_core.sv
hw/result_serializer.sv
hw/softmax_top.sv
test/softmax_tb.sv

//--- Bender.yml
package:
  name: softmax

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/softmax_pkg.sv
      - hw/vector_collector.sv
      - hw/serial_divider.sv
      - hw/softmax_core.sv
      - hw/result_serializer.sv
      - hw/softmax_top.sv
  - target: test
    include_dirs:
      - hw
      - test
    files:
      - test/softmax_tb.sv
